//--- sim/i3c_standby_stim.txt
# hand ccc_valid ibi_begin ccc_done ccc_next ibi_done owner | rx is_byte sda_bits rx_data
# timer t_free t_idle t_avail latency | enable en {avail,idle,free} | reset valid code det esc armed done {esc,periph}
hand 0 0 0 0 0 0
hand 1 0 0 0 0 1
rx 1 a5 a5
rx 0 1 01
hand 0 0 1 0 0 0
hand 1 1 0 0 0 0
hand 0 1 0 0 0 2
rx 1 3c 3c
hand 0 0 0 0 1 0
rx 0 0 00
hand 1 0 0 0 0 1
hand 0 0 0 1 0 0
timer 4 9 e 1
enable 0 0
reset 1 01 0 0 0 0 1
reset 0 00 0 0 0 1 0
reset 0 00 1 1 0 0 2
reset 0 00 1 0 1 0 2
reset 1 01 0 0 0 0 3
reset 0 00 0 0 0 1 2

//--- verilog.f
+incdir+include
rtl/i3c_bus_pkg.sv
rtl/i3c_xfer_pkg.sv
rtl/xfer_arbiter.sv
rtl/bus_rx_shifter.sv
rtl/bus_timers.sv
rtl/target_reset_ctrl.sv
rtl/i3c_standby_ctrl.sv
sim/i3c_standby_checker.sv
sim/tb_i3c_standby_ctrl.sv

//--- sim/tb_i3c_standby_ctrl.sv
// Testbench for the standby core: clock, reset, stimulus reader, routing model, checks, watchdog
`timescale 1ns/1ps

module tb_i3c_standby_ctrl
  import i3c_bus_pkg::*;
  import i3c_xfer_pkg::*;
();

  localparam StimFile = "sim/i3c_standby_stim.txt";
  localparam int CyclesPerLine = 200;

  logic        clk_i;
  logic        rst_ni;
  logic        ccc_valid_i, ibi_begin_i, ccc_done_i, ccc_next_i, ibi_done_i;
  tx_req_t     fsm_tx_req_i, ccc_tx_req_i, ibi_tx_req_i;
  rx_req_t     fsm_rx_req_i, ccc_rx_req_i, ibi_rx_req_i;
  xfer_rsp_t   fsm_rsp_o, ccc_rsp_o, ibi_rsp_o;
  xfer_owner_e owner_o;
  tx_req_t     bus_tx_req_o;
  logic        bus_tx_done_i, bus_tx_idle_i, bus_tx_err_i;
  bus_event_t  bus_evt_i;
  logic        bus_enable_i;
  bus_time_t   t_bus_free_i, t_bus_idle_i, t_bus_available_i;
  logic        bus_free_o, bus_idle_o, bus_available_o;
  rst_action_t rst_action_i;
  logic        rst_action_valid_i, target_reset_det_i, escalate_i, rstact_armed_i;
  logic        peripheral_reset_done_i;
  logic        peripheral_reset_o, escalated_reset_o;

  // Owner the model expects after the last hand-off
  xfer_owner_e cur_owner;

  i3c_standby_ctrl i3c_standby_ctrl_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  always @(i3c_standby_ctrl_i.u_standby_checker.assert_fails) begin
    if (i3c_standby_ctrl_i.u_standby_checker.assert_fails != 0) begin
      abort_run("A concurrent assertion in the bound checker failed");
    end
  end

  function automatic tx_req_t tx_of(input xfer_owner_e o);
    case (o)
      OwnerCcc: return ccc_tx_req_i;
      OwnerIbi: return ibi_tx_req_i;
      default:  return fsm_tx_req_i;
    endcase
  endfunction

  function automatic xfer_rsp_t rsp_of(input xfer_owner_e o);
    case (o)
      OwnerCcc: return ccc_rsp_o;
      OwnerIbi: return ibi_rsp_o;
      default:  return fsm_rsp_o;
    endcase
  endfunction

  // Engines that do not own the bus must see nothing
  task automatic check_others_zero(input xfer_owner_e o);
    if (o != OwnerFsm) check_eq("fsm_rsp_o", fsm_rsp_o, 32'h0);
    if (o != OwnerCcc) check_eq("ccc_rsp_o", ccc_rsp_o, 32'h0);
    if (o != OwnerIbi) check_eq("ibi_rsp_o", ibi_rsp_o, 32'h0);
  endtask

  task automatic hand_off(input logic [31:0] cv, ib, cd, cn, id, exp);
    xfer_rsp_t rsp;
    ccc_valid_i = cv[0];
    ibi_begin_i = ib[0];
    ccc_done_i  = cd[0];
    ccc_next_i  = cn[0];
    ibi_done_i  = id[0];
    @(negedge clk_i);
    ccc_valid_i = 1'b0;
    ibi_begin_i = 1'b0;
    ccc_done_i  = 1'b0;
    ccc_next_i  = 1'b0;
    ibi_done_i  = 1'b0;
    check_eq("owner_o", owner_o, exp);
    cur_owner = xfer_owner_e'(exp[1:0]);
    // Two patterns tell the three TX status bits apart
    bus_tx_done_i = 1'b1;
    bus_tx_idle_i = 1'b1;
    bus_tx_err_i  = 1'b0;
    @(negedge clk_i);
    rsp = rsp_of(cur_owner);
    check_eq("bus_tx_req_o", bus_tx_req_o, tx_of(cur_owner));
    check_eq("owner rsp tx status", {rsp.tx_done, rsp.tx_idle, rsp.tx_err}, 3'b110);
    check_others_zero(cur_owner);
    bus_tx_done_i = 1'b0;
    bus_tx_err_i  = 1'b1;
    @(negedge clk_i);
    rsp = rsp_of(cur_owner);
    check_eq("owner rsp tx status", {rsp.tx_done, rsp.tx_idle, rsp.tx_err}, 3'b011);
    check_others_zero(cur_owner);
    bus_tx_idle_i = 1'b0;
    bus_tx_err_i  = 1'b0;
  endtask

  task automatic rx_xfer(input logic [31:0] is_byte, bits, exp);
    xfer_rsp_t rsp;
    rx_req_t   req;
    int        nbits;
    int        waited;
    req   = is_byte[0] ? 2'b10 : 2'b01;
    nbits = is_byte[0] ? 8 : 1;
    case (cur_owner)
      OwnerCcc: ccc_rx_req_i = req;
      OwnerIbi: ibi_rx_req_i = req;
      default:  fsm_rx_req_i = req;
    endcase
    @(negedge clk_i);
    fsm_rx_req_i = '0;
    ccc_rx_req_i = '0;
    ibi_rx_req_i = '0;
    rsp = rsp_of(cur_owner);
    check_eq("owner rsp rx_idle", rsp.rx_idle, 1'b0);
    // MSB first with an idle cycle between SCL edges
    for (int i = nbits - 1; i >= 0; i--) begin
      bus_evt_i.scl_posedge = 1'b1;
      bus_evt_i.sda_value   = bits[i];
      @(negedge clk_i);
      bus_evt_i.scl_posedge = 1'b0;
      if (i > 0) begin
        @(negedge clk_i);
      end
    end
    waited = 0;
    rsp = rsp_of(cur_owner);
    while (!rsp.rx_done && waited < 16) begin
      @(negedge clk_i);
      waited++;
      rsp = rsp_of(cur_owner);
    end
    if (!rsp.rx_done) begin
      abort_run("The receiver never signalled done after the last SCL edge");
    end else begin
      check_eq("owner rsp rx_data", rsp.rx_data, exp);
      check_eq("owner rsp rx_idle", rsp.rx_idle, 1'b1);
      check_others_zero(cur_owner);
    end
  endtask

  task automatic timer_run(input logic [31:0] tf, ti, ta, lat);
    t_bus_free_i       = bus_time_t'(tf);
    t_bus_idle_i       = bus_time_t'(ti);
    t_bus_available_i  = bus_time_t'(ta);
    bus_enable_i       = 1'b1;
    bus_evt_i.stop_det = 1'b1;
    @(negedge clk_i);
    bus_evt_i.stop_det = 1'b0;
    // Cycle c counts clock edges after the one that saw STOP
    for (int c = 1; c <= ta + lat + 2; c++) begin
      @(negedge clk_i);
      check_eq("bus_free_o", bus_free_o, c >= tf + lat);
      check_eq("bus_idle_o", bus_idle_o, c >= ti + lat);
      check_eq("bus_available_o", bus_available_o, c >= ta + lat);
    end
  endtask

  task automatic enable_set(input logic [31:0] en, exp);
    bus_enable_i = en[0];
    @(negedge clk_i);
    check_eq("bus levels", {bus_available_o, bus_idle_o, bus_free_o}, exp);
  endtask

  task automatic reset_ops(input logic [31:0] av, code, det, esc, armed, done, exp);
    rst_action_valid_i      = av[0];
    rst_action_i            = code[7:0];
    target_reset_det_i      = det[0];
    escalate_i              = esc[0];
    rstact_armed_i          = armed[0];
    peripheral_reset_done_i = done[0];
    @(negedge clk_i);
    rst_action_valid_i      = 1'b0;
    target_reset_det_i      = 1'b0;
    peripheral_reset_done_i = 1'b0;
    check_eq("reset outputs", {escalated_reset_o, peripheral_reset_o}, exp);
  endtask

  initial begin : watchdog
    int              fd;
    int              lines;
    logic [8*256-1:0] line;
    lines = 0;
    fd = $fopen(StimFile, "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        lines++;
      end
      $fclose(fd);
    end
    repeat (20 + lines * CyclesPerLine) @(posedge clk_i);
    abort_run("Timeout: the stimulus did not complete in the allowed number of cycles");
  end

  initial begin : stimulus
    int               fd;
    int               code;
    logic [8*16-1:0]  cmd;
    logic [8*256-1:0] rest;
    logic [31:0]      a, b, c, d, e, f, g;
    rst_ni                  = 1'b0;
    ccc_valid_i             = 1'b0;
    ibi_begin_i             = 1'b0;
    ccc_done_i              = 1'b0;
    ccc_next_i              = 1'b0;
    ibi_done_i              = 1'b0;
    fsm_tx_req_i            = '{req_byte: 1'b1, req_bit: 1'b0, value: 8'h3c, sel_od_pp: 1'b0};
    ccc_tx_req_i            = '{req_byte: 1'b0, req_bit: 1'b1, value: 8'h81, sel_od_pp: 1'b1};
    ibi_tx_req_i            = '{req_byte: 1'b1, req_bit: 1'b0, value: 8'h5a, sel_od_pp: 1'b1};
    fsm_rx_req_i            = '0;
    ccc_rx_req_i            = '0;
    ibi_rx_req_i            = '0;
    bus_tx_done_i           = 1'b0;
    bus_tx_idle_i           = 1'b0;
    bus_tx_err_i            = 1'b0;
    bus_evt_i               = '0;
    bus_enable_i            = 1'b0;
    t_bus_free_i            = '0;
    t_bus_idle_i            = '0;
    t_bus_available_i       = '0;
    rst_action_i            = '0;
    rst_action_valid_i      = 1'b0;
    target_reset_det_i      = 1'b0;
    escalate_i              = 1'b0;
    rstact_armed_i          = 1'b0;
    peripheral_reset_done_i = 1'b0;
    cur_owner               = OwnerFsm;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_eq("owner_o", owner_o, OwnerFsm);
    check_eq("fsm_rsp_o", fsm_rsp_o, 32'h100);
    check_eq("bus levels", {bus_available_o, bus_idle_o, bus_free_o}, 3'b000);
    check_eq("reset outputs", {escalated_reset_o, peripheral_reset_o}, 2'b00);
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file");
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", cmd);
        if (code == 1) begin
          if (cmd == "#") begin
            code = $fgets(rest, fd);
          end else if (cmd == "hand") begin
            code = $fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, e, f);
            hand_off(a, b, c, d, e, f);
          end else if (cmd == "rx") begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            rx_xfer(a, b, c);
          end else if (cmd == "timer") begin
            code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
            timer_run(a, b, c, d);
          end else if (cmd == "enable") begin
            code = $fscanf(fd, "%h %h", a, b);
            enable_set(a, b);
          end else if (cmd == "reset") begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h", a, b, c, d, e, f, g);
            reset_ops(a, b, c, d, e, f, g);
          end else begin
            abort_run("Unknown command in the stimulus file");
          end
        end
      end
      $fclose(fd);
      $display("Regression passed");
      $finish;
    end
  end

endmodule

//--- sim/i3c_standby_checker.sv
// Concurrent assertions on the receiver, reset control and owner hand-off of the standby core
`timescale 1ns/1ps

module i3c_standby_checker
  import i3c_xfer_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input logic        rx_done_i,
  input logic        escalated_reset_i,
  input logic        ccc_valid_i,
  input logic        ibi_begin_i,
  input xfer_owner_e owner_i
);

  // Count of failed assertions
  int unsigned assert_fails = 0;

  // Done is a single-cycle pulse
  a_rx_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_done_i |=> !rx_done_i)
    else begin
      assert_fails++;
      $error("rx_done held high for more than one cycle");
    end

  // Escalated reset only clears with the chip reset
  a_escalated_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    escalated_reset_i |=> escalated_reset_i)
    else begin
      assert_fails++;
      $error("escalated_reset_o fell while out of reset");
    end

  a_owner_handoff: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (owner_i == OwnerFsm && (ccc_valid_i ^ ibi_begin_i)) |=> owner_i != OwnerFsm)
    else begin
      assert_fails++;
      $error("owner stayed with the FSM after a single hand-off request");
    end

endmodule

bind i3c_standby_ctrl i3c_standby_checker u_standby_checker (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .rx_done_i         (rx_done),
  .escalated_reset_i (escalated_reset_o),
  .ccc_valid_i       (ccc_valid_i),
  .ibi_begin_i       (ibi_begin_i),
  .owner_i           (owner_o)
);

//--- rtl/i3c_standby_ctrl.sv
// Top level of the standby coordination core: arbiter, receiver, timers, reset control
`timescale 1ns/1ps

module i3c_standby_ctrl
  import i3c_bus_pkg::*;
  import i3c_xfer_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // Engine hand-off
  input  logic        ccc_valid_i,
  input  logic        ibi_begin_i,
  input  logic        ccc_done_i,
  input  logic        ccc_next_i,
  input  logic        ibi_done_i,

  // Engine requests and responses
  input  tx_req_t     fsm_tx_req_i,
  input  tx_req_t     ccc_tx_req_i,
  input  tx_req_t     ibi_tx_req_i,
  input  rx_req_t     fsm_rx_req_i,
  input  rx_req_t     ccc_rx_req_i,
  input  rx_req_t     ibi_rx_req_i,
  output xfer_rsp_t   fsm_rsp_o,
  output xfer_rsp_t   ccc_rsp_o,
  output xfer_rsp_t   ibi_rsp_o,
  output xfer_owner_e owner_o,

  // SDA transmitter
  output tx_req_t     bus_tx_req_o,
  input  logic        bus_tx_done_i,
  input  logic        bus_tx_idle_i,
  input  logic        bus_tx_err_i,

  // Bus conditions
  input  bus_event_t  bus_evt_i,
  input  logic        bus_enable_i,
  input  bus_time_t   t_bus_free_i,
  input  bus_time_t   t_bus_idle_i,
  input  bus_time_t   t_bus_available_i,
  output logic        bus_free_o,
  output logic        bus_idle_o,
  output logic        bus_available_o,

  // Target reset
  input  rst_action_t rst_action_i,
  input  logic        rst_action_valid_i,
  input  logic        target_reset_det_i,
  input  logic        escalate_i,
  input  logic        rstact_armed_i,
  input  logic        peripheral_reset_done_i,
  output logic        peripheral_reset_o,
  output logic        escalated_reset_o
);

  rx_req_t   bus_rx_req;
  bus_byte_t rx_data;
  logic      rx_done;
  logic      rx_idle;

  xfer_arbiter u_xfer_arbiter (
    .clk_i,
    .rst_ni,
    .ccc_valid_i,
    .ibi_begin_i,
    .ccc_done_i,
    .ccc_next_i,
    .ibi_done_i,
    .fsm_tx_req_i,
    .ccc_tx_req_i,
    .ibi_tx_req_i,
    .fsm_rx_req_i,
    .ccc_rx_req_i,
    .ibi_rx_req_i,
    .bus_tx_done_i,
    .bus_tx_idle_i,
    .bus_tx_err_i,
    .rx_done_i    (rx_done),
    .rx_idle_i    (rx_idle),
    .rx_data_i    (rx_data),
    .bus_tx_req_o,
    .bus_rx_req_o (bus_rx_req),
    .fsm_rsp_o,
    .ccc_rsp_o,
    .ibi_rsp_o,
    .owner_o
  );

  bus_rx_shifter u_bus_rx_shifter (
    .clk_i,
    .rst_ni,
    .bus_evt_i,
    .rx_req_i  (bus_rx_req),
    .rx_data_o (rx_data),
    .rx_done_o (rx_done),
    .rx_idle_o (rx_idle)
  );

  bus_timers u_bus_timers (
    .clk_i,
    .rst_ni,
    .bus_enable_i,
    .bus_evt_i,
    .t_bus_free_i,
    .t_bus_idle_i,
    .t_bus_available_i,
    .bus_free_o,
    .bus_idle_o,
    .bus_available_o
  );

  target_reset_ctrl u_target_reset_ctrl (
    .clk_i,
    .rst_ni,
    .rst_action_i,
    .rst_action_valid_i,
    .target_reset_det_i,
    .escalate_i,
    .rstact_armed_i,
    .peripheral_reset_done_i,
    .peripheral_reset_o,
    .escalated_reset_o
  );

endmodule

//--- rtl/target_reset_ctrl.sv
// Peripheral and escalated reset outputs driven by RSTACT and target-reset patterns
`timescale 1ns/1ps
`include "i3c_standby_cfg.svh"

module target_reset_ctrl
  import i3c_xfer_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  rst_action_t rst_action_i,
  input  logic        rst_action_valid_i,
  input  logic        target_reset_det_i,
  input  logic        escalate_i,
  input  logic        rstact_armed_i,
  input  logic        peripheral_reset_done_i,
  output logic        peripheral_reset_o,
  output logic        escalated_reset_o
);

  logic periph_trig;
  logic escalate_trig;
  logic periph_q;
  logic escalated_q;

  // First reset pattern resets the peripheral, a second one escalates
  assign periph_trig = (rst_action_valid_i && rst_action_i == `I3C_RSTACT_PERIPH) ||
                       (target_reset_det_i && !escalate_i && !rstact_armed_i);
  assign escalate_trig = (rst_action_valid_i && rst_action_i == `I3C_RSTACT_ESCALATE) ||
                         (target_reset_det_i && escalate_i && !rstact_armed_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      periph_q <= 1'b0;
    end else if (peripheral_reset_done_i) begin
      periph_q <= 1'b0;
    end else if (periph_trig) begin
      periph_q <= 1'b1;
    end
  end

  // Sticky until the next chip reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      escalated_q <= 1'b0;
    end else if (escalate_trig) begin
      escalated_q <= 1'b1;
    end
  end

  assign peripheral_reset_o = periph_q;
  assign escalated_reset_o  = escalated_q;

endmodule

//--- rtl/bus_timers.sv
// Bus free, idle and available detection from a counter restarted at STOP
`timescale 1ns/1ps

module bus_timers
  import i3c_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       bus_enable_i,
  input  bus_event_t bus_evt_i,
  input  bus_time_t  t_bus_free_i,
  input  bus_time_t  t_bus_idle_i,
  input  bus_time_t  t_bus_available_i,
  output logic       bus_free_o,
  output logic       bus_idle_o,
  output logic       bus_available_o
);

  bus_time_t count_q;
  logic      free_q;
  logic      idle_q;
  logic      available_q;

  // Saturating count of clocks since the last STOP
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (!bus_enable_i || bus_evt_i.stop_det) begin
      count_q <= '0;
    end else if (count_q != '1) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Levels lag the count by one clock
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      free_q      <= 1'b0;
      idle_q      <= 1'b0;
      available_q <= 1'b0;
    end else begin
      free_q      <= bus_enable_i && (count_q >= t_bus_free_i);
      idle_q      <= bus_enable_i && (count_q >= t_bus_idle_i);
      available_q <= bus_enable_i && (count_q >= t_bus_available_i);
    end
  end

  assign bus_free_o      = free_q;
  assign bus_idle_o      = idle_q;
  assign bus_available_o = available_q;

endmodule

//--- rtl/bus_rx_shifter.sv
// SDA receiver for one bit or one byte, sampled on SCL rising edges
`timescale 1ns/1ps
`include "i3c_standby_cfg.svh"

module bus_rx_shifter
  import i3c_bus_pkg::*;
  import i3c_xfer_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  bus_event_t bus_evt_i,
  input  rx_req_t    rx_req_i,
  output bus_byte_t  rx_data_o,
  output logic       rx_done_o,
  output logic       rx_idle_o
);

  localparam int unsigned CntW = $clog2(`I3C_BYTE_W + 1);

  bus_byte_t       shift_q;
  logic [CntW-1:0] remain_q;
  logic            idle_q;
  logic            done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shift_q  <= '0;
      remain_q <= '0;
      idle_q   <= 1'b1;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (idle_q) begin
        // Byte request wins if both strobes show up together
        if (rx_req_i.req_byte || rx_req_i.req_bit) begin
          shift_q  <= '0;
          remain_q <= rx_req_i.req_byte ? CntW'(`I3C_BYTE_W) : CntW'(1);
          idle_q   <= 1'b0;
        end
      end else if (bus_evt_i.scl_posedge) begin
        // MSB first, so a lone bit ends up in bit 0
        shift_q  <= {shift_q[`I3C_BYTE_W-2:0], bus_evt_i.sda_value};
        remain_q <= remain_q - 1'b1;
        if (remain_q == CntW'(1)) begin
          done_q <= 1'b1;
          idle_q <= 1'b1;
        end
      end
    end
  end

  assign rx_data_o = shift_q;
  assign rx_done_o = done_q;
  assign rx_idle_o = idle_q;

endmodule

//--- rtl/xfer_arbiter.sv
// Transfer-owner register and request/response routing between the three engines
`timescale 1ns/1ps

module xfer_arbiter
  import i3c_bus_pkg::*;
  import i3c_xfer_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        ccc_valid_i,
  input  logic        ibi_begin_i,
  input  logic        ccc_done_i,
  input  logic        ccc_next_i,
  input  logic        ibi_done_i,

  input  tx_req_t     fsm_tx_req_i,
  input  tx_req_t     ccc_tx_req_i,
  input  tx_req_t     ibi_tx_req_i,
  input  rx_req_t     fsm_rx_req_i,
  input  rx_req_t     ccc_rx_req_i,
  input  rx_req_t     ibi_rx_req_i,

  input  logic        bus_tx_done_i,
  input  logic        bus_tx_idle_i,
  input  logic        bus_tx_err_i,
  input  logic        rx_done_i,
  input  logic        rx_idle_i,
  input  bus_byte_t   rx_data_i,

  output tx_req_t     bus_tx_req_o,
  output rx_req_t     bus_rx_req_o,
  output xfer_rsp_t   fsm_rsp_o,
  output xfer_rsp_t   ccc_rsp_o,
  output xfer_rsp_t   ibi_rsp_o,
  output xfer_owner_e owner_o
);

  xfer_owner_e owner_q;
  xfer_owner_e owner_d;
  xfer_rsp_t   bus_rsp;

  // Hand-off only leaves the FSM on an unambiguous request
  always_comb begin
    owner_d = owner_q;
    unique case (owner_q)
      OwnerFsm: begin
        if (ccc_valid_i && !ibi_begin_i) begin
          owner_d = OwnerCcc;
        end else if (ibi_begin_i && !ccc_valid_i) begin
          owner_d = OwnerIbi;
        end
      end
      OwnerCcc: begin
        if (ccc_done_i || ccc_next_i) begin
          owner_d = OwnerFsm;
        end
      end
      OwnerIbi: begin
        if (ibi_done_i) begin
          owner_d = OwnerFsm;
        end
      end
      default: owner_d = OwnerFsm;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= OwnerFsm;
    end else begin
      owner_q <= owner_d;
    end
  end

  assign bus_rsp = '{
    tx_done: bus_tx_done_i,
    tx_idle: bus_tx_idle_i,
    tx_err:  bus_tx_err_i,
    rx_done: rx_done_i,
    rx_idle: rx_idle_i,
    rx_data: rx_data_i
  };

  // Non-owners see an all-zero response
  always_comb begin
    bus_tx_req_o = '0;
    bus_rx_req_o = '0;
    fsm_rsp_o    = '0;
    ccc_rsp_o    = '0;
    ibi_rsp_o    = '0;
    unique case (owner_q)
      OwnerFsm: begin
        bus_tx_req_o = fsm_tx_req_i;
        bus_rx_req_o = fsm_rx_req_i;
        fsm_rsp_o    = bus_rsp;
      end
      OwnerCcc: begin
        bus_tx_req_o = ccc_tx_req_i;
        bus_rx_req_o = ccc_rx_req_i;
        ccc_rsp_o    = bus_rsp;
      end
      OwnerIbi: begin
        bus_tx_req_o = ibi_tx_req_i;
        bus_rx_req_o = ibi_rx_req_i;
        ibi_rsp_o    = bus_rsp;
      end
      default: ;
    endcase
  end

  assign owner_o = owner_q;

endmodule

//--- rtl/i3c_xfer_pkg.sv
// Transfer-side types: owner enum, engine request and response bundles, reset action
`include "i3c_standby_cfg.svh"

package i3c_xfer_pkg;

  import i3c_bus_pkg::*;

  // Engine that currently owns the shared TX and RX engines
  typedef enum logic [1:0] {
    OwnerFsm,
    OwnerCcc,
    OwnerIbi
  } xfer_owner_e;

  // Transmit request towards the timed SDA driver
  typedef struct packed {
    logic      req_byte;
    logic      req_bit;
    bus_byte_t value;
    logic      sel_od_pp;
  } tx_req_t;

  // Receive request towards the SDA sampler
  typedef struct packed {
    logic req_byte;
    logic req_bit;
  } rx_req_t;

  // Status returned to the owning engine
  typedef struct packed {
    logic      tx_done;
    logic      tx_idle;
    logic      tx_err;
    logic      rx_done;
    logic      rx_idle;
    bus_byte_t rx_data;
  } xfer_rsp_t;

  // Defining byte of the RSTACT CCC
  typedef logic [7:0] rst_action_t;

endpackage

//--- rtl/i3c_bus_pkg.sv
// Bus-side types: bus event bundle, timer counts and bus bytes
`include "i3c_standby_cfg.svh"

package i3c_bus_pkg;

  // Data byte as shifted in or out on SDA
  typedef logic [`I3C_BYTE_W-1:0] bus_byte_t;

  // Timing threshold or clock count
  typedef logic [`I3C_TIMER_W-1:0] bus_time_t;

  // Per-cycle bus conditions from the bus monitor
  typedef struct packed {
    logic start_det;
    logic rstart_det;
    logic stop_det;
    logic scl_posedge;
    logic sda_value;
  } bus_event_t;

endpackage

//--- include/i3c_standby_cfg.svh
// Widths and reset-action codes shared by the I3C standby controller
`ifndef I3C_STANDBY_CFG_SVH
`define I3C_STANDBY_CFG_SVH

// Bus timing thresholds and the bus-condition counter
`define I3C_TIMER_W 20

// One data byte on the I3C bus
`define I3C_BYTE_W 8

// RSTACT defining bytes that this target acts on
`define I3C_RSTACT_PERIPH 8'h01
`define I3C_RSTACT_ESCALATE 8'h02

`endif
